// ==== design/mips_alu.sv ====
`default_nettype none

module mips_alu (
    input  logic [31:0]       a,
    input  logic [31:0]       b,
    input  mips_pkg::alu_op_e op,
    output logic [31:0]       y,
    output logic              zero
);

    import mips_pkg::*;

    logic [31:0] sum;
    logic [31:0] diff;
    logic        lt;                        // Signed a < b

    assign sum  = a + b;
    assign diff = a - b;
    assign lt   = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            alu_add: begin
                y = sum;
            end
            alu_sub: begin
                y = diff;                   // Also the beq compare
            end
            alu_and: begin
                y = a & b;
            end
            alu_or: begin
                y = a | b;
            end
            alu_slt: begin
                y = {31'd0, lt};
            end
            default: begin
                y = 32'd0;                  // Unused encodings
            end
        endcase
    end

    // Equal operands when op is sub
    assign zero = (y == 32'd0);

endmodule

`default_nettype wire

// ==== design/mips_core.sv ====
`default_nettype none

module mips_core (
    input  logic             clock,
    input  logic             rst_n,
    input  mips_pkg::instr_u instr,
    input  logic [31:0]      dmem_rd,
    output logic [31:0]      pc,
    output logic [31:0]      dmem_addr,
    output logic [31:0]      dmem_wd,
    output logic             dmem_we
);

    import mips_pkg::*;

    mips_ctrl_t  ctrl;                      // Decode to execute and result
    logic [31:0] alu_y;
    logic [31:0] pc_plus4;
    logic [31:0] branch_target;
    logic [31:0] jump_target;
    logic [31:0] wr_data;                   // Write-back to regfile
    logic [31:0] pc_next;
    logic        zero;

    assign dmem_addr = alu_y;               // Effective address
    assign dmem_we   = ctrl.dmem_we;

    mips_decoder mips_decoder_inst (
        .clock (clock),
        .rst_n (rst_n),
        .instr (instr),
        .ctrl  (ctrl)
    );

    mips_datapath mips_datapath_inst (
        .clock         (clock),
        .rst_n         (rst_n),
        .instr         (instr),
        .ctrl          (ctrl),
        .wr_data       (wr_data),
        .pc_next       (pc_next),
        .pc            (pc),
        .alu_y         (alu_y),
        .pc_plus4      (pc_plus4),
        .branch_target (branch_target),
        .jump_target   (jump_target),
        .dmem_wd       (dmem_wd),
        .zero          (zero)
    );

    mips_result_select mips_result_select_inst (
        .ctrl          (ctrl),
        .alu_y         (alu_y),
        .dmem_rd       (dmem_rd),
        .pc_plus4      (pc_plus4),
        .branch_target (branch_target),
        .jump_target   (jump_target),
        .zero          (zero),
        .wr_data       (wr_data),
        .pc_next       (pc_next)
    );

endmodule

`default_nettype wire

// ==== design/mips_datapath.sv ====
`default_nettype none

module mips_datapath (
    input  logic                 clock,
    input  logic                 rst_n,
    input  mips_pkg::instr_u     instr,
    input  mips_pkg::mips_ctrl_t ctrl,
    input  logic [31:0]          wr_data,
    input  logic [31:0]          pc_next,
    output logic [31:0]          pc,
    output logic [31:0]          alu_y,
    output logic [31:0]          pc_plus4,
    output logic [31:0]          branch_target,
    output logic [31:0]          jump_target,
    output logic [31:0]          dmem_wd,
    output logic                 zero
);

    import mips_pkg::*;

    logic [4:0]  wa;                        // Register write address
    logic [31:0] sign_imm;
    logic [31:0] rs_data;
    logic [31:0] rt_data;
    logic [31:0] alu_b;

    ////////////////////////////////////////////////////////////
    // Program counter
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            pc <= reset_pc;
        end else begin
            pc <= pc_next;                  // One instruction per clock
        end
    end

    assign pc_plus4 = pc + 32'd4;

    // Immediate and targets
    assign sign_imm      = {{16{instr.i.imm[15]}}, instr.i.imm};
    assign branch_target = pc_plus4 + {sign_imm[29:0], 2'b00};      // Word offset
    assign jump_target   = {pc_plus4[31:28], instr.raw[25:0], 2'b00};

    ////////////////////////////////////////////////////////////
    // Register file
    ////////////////////////////////////////////////////////////

    // Destination register
    always_comb begin
        case (ctrl.wa_sel)
            wa_rt:   wa = instr.i.rt;
            wa_rd:   wa = instr.r.rd;
            wa_ra:   wa = reg_ra;
            default: wa = 5'd0;             // r0 swallows the write
        endcase
    end

    mips_regfile mips_regfile_inst (
        .clock (clock),
        .we    (ctrl.rf_we),
        .wa    (wa),
        .ra0   (instr.i.rs),
        .ra1   (instr.i.rt),
        .wd    (wr_data),
        .rd0   (rs_data),
        .rd1   (rt_data)
    );

    assign dmem_wd = rt_data;               // Store data is rt

    ////////////////////////////////////////////////////////////
    // ALU
    ////////////////////////////////////////////////////////////

    assign alu_b = ctrl.alu_b_imm ? sign_imm : rt_data;

    mips_alu mips_alu_inst (
        .a    (rs_data),
        .b    (alu_b),
        .op   (ctrl.alu_op),
        .y    (alu_y),
        .zero (zero)
    );

endmodule

`default_nettype wire

// ==== design/mips_decoder.sv ====
`default_nettype none

module mips_decoder (
    input  logic                clock,      // For bound checks only
    input  logic                rst_n,
    input  mips_pkg::instr_u    instr,
    output mips_pkg::mips_ctrl_t ctrl
);

    import mips_pkg::*;

    logic [7:0] opcode;                     // Widened to match op_* constants
    mips_ctrl_t dec;                        // Decode before reset masking

    assign opcode = {2'b00, instr.r.opcode};

    ////////////////////////////////////////////////////////////
    // Opcode and funct decode
    ////////////////////////////////////////////////////////////

    always_comb begin
        // Default is a no-op
        dec            = '0;
        dec.alu_op     = alu_add;
        dec.wa_sel     = wa_rt;
        dec.result_sel = res_alu;

        case (opcode)
            op_rtype: begin
                dec.wa_sel = wa_rd;
                dec.rf_we  = 1'b1;
                case (instr.r.funct)
                    fn_add:  dec.alu_op = alu_add;
                    fn_sub:  dec.alu_op = alu_sub;
                    fn_and:  dec.alu_op = alu_and;
                    fn_or:   dec.alu_op = alu_or;
                    fn_slt:  dec.alu_op = alu_slt;
                    default: dec.rf_we  = 1'b0;     // Unknown funct, no write
                endcase
            end
            op_addi: begin
                dec.rf_we     = 1'b1;
                dec.alu_b_imm = 1'b1;
            end
            op_lw: begin
                dec.rf_we      = 1'b1;
                dec.alu_b_imm  = 1'b1;              // Base plus offset
                dec.result_sel = res_mem;
            end
            op_sw: begin
                dec.dmem_we   = 1'b1;
                dec.alu_b_imm = 1'b1;
            end
            op_beq: begin
                dec.is_branch = 1'b1;
                dec.alu_op    = alu_sub;            // Zero flag means equal
            end
            op_j: begin
                dec.is_jump = 1'b1;
            end
            op_jal: begin
                dec.is_jump    = 1'b1;
                dec.rf_we      = 1'b1;
                dec.wa_sel     = wa_ra;             // Link into r31
                dec.result_sel = res_pc4;
            end
            default: ;                              // Stays a no-op
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Reset masking
    ////////////////////////////////////////////////////////////

    always_comb begin
        ctrl = dec;
        if (!rst_n) begin
            ctrl.rf_we   = 1'b0;                    // No state change in reset
            ctrl.dmem_we = 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== design/mips_pkg.sv ====
`default_nettype none

package mips_pkg;

    ////////////////////////////////////////////////////////////
    // Instruction formats
    ////////////////////////////////////////////////////////////

    // R-type view
    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;                  // Unused by this subset
        logic [5:0] funct;
    } instr_r_t;

    // I-type view
    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;                   // Sign extended in execute
    } instr_i_t;

    // One fetched word, seen as R, I or raw
    typedef union packed {
        instr_r_t    r;
        instr_i_t    i;
        logic [31:0] raw;                   // Jump index lives in raw[25:0]
    } instr_u;

    ////////////////////////////////////////////////////////////
    // Control encodings
    ////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_slt
    } alu_op_e;

    typedef enum logic [1:0] {
        wa_rt,                              // I-type destination
        wa_rd,                              // R-type destination
        wa_ra                               // Link register for jal
    } wa_sel_e;

    typedef enum logic [1:0] {
        res_alu,
        res_mem,
        res_pc4                             // Return address
    } result_sel_e;

    typedef enum logic [1:0] {
        pc_seq,
        pc_branch,
        pc_jump
    } pc_sel_e;

    // Control bus out of decode
    typedef struct packed {
        logic        rf_we;
        logic        dmem_we;
        logic        alu_b_imm;             // ALU B from immediate
        logic        is_branch;
        logic        is_jump;
        alu_op_e     alu_op;
        wa_sel_e     wa_sel;
        result_sel_e result_sel;
    } mips_ctrl_t;

    // Opcodes
    localparam logic [7:0] op_rtype = 8'h00;
    localparam logic [7:0] op_j     = 8'h02;
    localparam logic [7:0] op_jal   = 8'h03;
    localparam logic [7:0] op_beq   = 8'h04;
    localparam logic [7:0] op_addi  = 8'h08;
    localparam logic [7:0] op_lw    = 8'h23;
    localparam logic [7:0] op_sw    = 8'h2b;

    // Function codes, R-type only
    localparam logic [5:0] fn_add = 6'h20;
    localparam logic [5:0] fn_sub = 6'h22;
    localparam logic [5:0] fn_and = 6'h24;
    localparam logic [5:0] fn_or  = 6'h25;
    localparam logic [5:0] fn_slt = 6'h2a;

    localparam logic [4:0]  reg_ra   = 5'd31;
    localparam logic [31:0] reset_pc = 32'h0000_0000;

endpackage

`default_nettype wire

// ==== design/mips_regfile.sv ====
`default_nettype none

module mips_regfile (
    input  logic        clock,
    input  logic        we,
    input  logic [4:0]  wa,
    input  logic [4:0]  ra0,
    input  logic [4:0]  ra1,
    input  logic [31:0] wd,
    output logic [31:0] rd0,
    output logic [31:0] rd1
);

    logic [31:0] regs [32];                 // Storage, r0 never written

    // Write port
    always_ff @(posedge clock) begin
        if (we && (wa != 5'd0)) begin
            regs[wa] <= wd;
        end
    end

    // Asynchronous reads, r0 reads as zero
    always_comb begin
        if (ra0 == 5'd0) begin
            rd0 = 32'd0;
        end else begin
            rd0 = regs[ra0];
        end
    end

    always_comb begin
        if (ra1 == 5'd0) begin
            rd1 = 32'd0;
        end else begin
            rd1 = regs[ra1];
        end
    end

endmodule

`default_nettype wire

// ==== design/mips_result_select.sv ====
`default_nettype none

module mips_result_select (
    input  mips_pkg::mips_ctrl_t ctrl,
    input  logic [31:0]          alu_y,
    input  logic [31:0]          dmem_rd,
    input  logic [31:0]          pc_plus4,
    input  logic [31:0]          branch_target,
    input  logic [31:0]          jump_target,
    input  logic                 zero,
    output logic [31:0]          wr_data,
    output logic [31:0]          pc_next
);

    import mips_pkg::*;

    pc_sel_e pc_sel;

    // Write-back source
    always_comb begin
        case (ctrl.result_sel)
            res_alu: wr_data = alu_y;
            res_mem: wr_data = dmem_rd;     // Load data, same cycle
            res_pc4: wr_data = pc_plus4;    // jal link
            default: wr_data = alu_y;
        endcase
    end

    // Jump wins, then taken branch
    always_comb begin
        if (ctrl.is_jump) begin
            pc_sel = pc_jump;
        end else if (ctrl.is_branch && zero) begin
            pc_sel = pc_branch;
        end else begin
            pc_sel = pc_seq;
        end
    end

    always_comb begin
        case (pc_sel)
            pc_branch: pc_next = branch_target;
            pc_jump:   pc_next = jump_target;
            default:   pc_next = pc_plus4;
        endcase
    end

endmodule

`default_nettype wire

// ==== mips_core.f ====
design/mips_pkg.sv
design/mips_regfile.sv
design/mips_alu.sv
design/mips_decoder.sv
design/mips_datapath.sv
design/mips_result_select.sv
design/mips_core.sv
verification/mips_core_assertions.sv
verification/mips_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the mips_core testbench under Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module mips_core_tb -f mips_core.f \
    -o mips_core_sim || { echo "Build failed"; exit 1; }
./obj_dir/mips_core_sim > sim.log 2>&1
cat sim.log
# Verdict comes from the log
grep -q "Checks failed" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "All checks passed" sim.log || { echo "Simulation ended without a verdict"; exit 1; }
echo "Simulation passed"

// ==== verification/mips_core_assertions.sv ====
`default_nettype none

module mips_core_assertions (
    input logic                 clock,
    input logic                 rst_n,
    input logic [31:0]          pc,
    input logic                 dmem_we,
    input mips_pkg::mips_ctrl_t ctrl
);

    timeunit 1ns;
    timeprecision 1ps;

    import mips_pkg::*;

    // Fetch address on a word boundary
    pc_aligned: assert property (@(posedge clock) disable iff (!rst_n) pc[1:0] == 2'b00)
        else $error("pc %h is not word aligned", pc);

    we_low_in_reset: assert property (@(posedge clock) !rst_n |-> !dmem_we)
        else $error("dmem_we high while rst_n is low");

    // First cycle out of reset
    pc_after_reset: assert property (@(posedge clock) $rose(rst_n) |-> pc == reset_pc)
        else $error("pc %h is not the reset address after reset", pc);

    store_no_rf_write: assert property (@(posedge clock) ctrl.dmem_we |-> !ctrl.rf_we)
        else $error("Store also writes the register file");

endmodule

bind mips_core mips_core_assertions mips_core_assertions_inst (
    .clock   (clock),
    .rst_n   (rst_n),
    .pc      (pc),
    .dmem_we (dmem_we),
    .ctrl    (ctrl)
);

`default_nettype wire

// ==== verification/mips_core_tb.sv ====
`default_nettype none

module mips_core_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import mips_pkg::*;

    localparam int clk_period   = 20;
    localparam int reset_cycles = 4;
    localparam int prog_len     = 200;              // Words, seed prologue included
    localparam int margin       = 20;               // Spare cycles for the watchdog
    localparam logic [31:0] end_pc = 32'(prog_len * 4);
    localparam logic [5:0] functs [8] = '{fn_add, fn_sub, fn_and, fn_or,
                                          fn_slt, fn_slt, fn_add, fn_sub};
    // Store presented while reset is held
    localparam logic [31:0] reset_instr = {op_sw[5:0], 5'd0, 5'd0, 16'h0010};

    // Expected effect of one instruction
    typedef struct packed {
        logic [31:0] next_pc;
        logic        mem_access;                    // lw or sw
        logic        mem_we;
        logic [31:0] addr;
        logic [31:0] st_data;
        logic        reg_we;
        logic [4:0]  reg_wa;
        logic [31:0] reg_wd;
    } ref_result_t;

    logic        clock;
    logic        rst_n;
    instr_u      instr;
    logic [31:0] dmem_rd;
    logic [31:0] pc;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wd;
    logic        dmem_we;

    logic [31:0] imem [256];
    logic [31:0] dmem [64];
    logic [31:0] ref_regs [32];
    logic [31:0] ref_mem [64];
    logic        link_store [256];              // Slot reached by a jal
    logic [31:0] lfsr;
    logic [31:0] exp_pc;                        // Pc the core holds this cycle
    logic        fetch_on;                      // Program words instead of reset store
    int          errors;

    mips_core mips_core_inst (
        .clock     (clock),
        .rst_n     (rst_n),
        .instr     (instr),
        .dmem_rd   (dmem_rd),
        .pc        (pc),
        .dmem_addr (dmem_addr),
        .dmem_wd   (dmem_wd),
        .dmem_we   (dmem_we)
    );

    always #(clk_period / 2) clock = ~clock;

    // Data memory, asynchronous read
    assign dmem_rd = dmem[dmem_addr[7:2]];
    always @(posedge clock) begin
        if (dmem_we) begin
            dmem[dmem_addr[7:2]] <= dmem_wd;
        end
    end

    // Word for the pc the core takes on this edge
    always @(posedge clock) begin
        if (fetch_on) begin
            instr <= imem[exp_pc[9:2]];
        end else begin
            instr <= reset_instr;               // Write enable must stay masked
        end
    end

    ////////////////////////////////////////////////////////////
    // Random source and program
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;    // x^32 + x^22 + x^2 + x + 1
        end else begin
            return s >> 1;
        end
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = 32'd0;
        for (int k = 0; k < n; k++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);             // One step per bit
        end
        return v;
    endfunction

    task automatic build_program();
        logic [2:0]  pick;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
        int          tgt;
        for (int i = 0; i < 256; i++) begin
            imem[i]       = 32'd0;              // Unknown funct, acts as no-op
            link_store[i] = 1'b0;
        end
        // Seed r1 to r31
        for (int i = 1; i < 32; i++) begin
            imem[i - 1] = {op_addi[5:0], 5'd0, 5'(i), 16'(rand_bits(16))};
        end
        for (int i = 31; i < prog_len; i++) begin
            rs   = 5'(rand_bits(5));
            rt   = 5'(rand_bits(5));
            imm  = 16'(rand_bits(16));
            tgt  = i + 1 + int'(rand_bits(3));  // Forward only
            pick = 3'(rand_bits(3));
            if (tgt > prog_len) begin
                tgt = prog_len;
            end
            if (link_store[i]) begin
                pick = 3'd4;                    // Store r31 to expose the link
                rt   = reg_ra;
            end
            case (pick)
                3'd0, 3'd1: imem[i] = {6'd0, rs, rt, 5'(rand_bits(5)), 5'd0,
                                       functs[3'(rand_bits(3))]};
                3'd2:       imem[i] = {op_addi[5:0], rs, rt, imm};
                3'd3:       imem[i] = {op_lw[5:0], rs, rt, imm};
                3'd4, 3'd5: imem[i] = {op_sw[5:0], rs, rt, imm};
                3'd6: begin
                    if (rand_bits(1) != 0) begin
                        rt = rs;                // Taken branch
                    end
                    imem[i] = {op_beq[5:0], rs, rt, 16'(tgt - i - 1)};
                end
                default: begin
                    if (rand_bits(1) != 0) begin
                        imem[i]         = {op_jal[5:0], 26'(tgt)};
                        link_store[tgt] = 1'b1;
                    end else begin
                        imem[i] = {op_j[5:0], 26'(tgt)};
                    end
                end
            endcase
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Reference model and checks
    ////////////////////////////////////////////////////////////

    function automatic ref_result_t exec_ref(input logic [31:0] cur_pc, input logic [31:0] w);
        ref_result_t r;
        logic [31:0] a;
        logic [31:0] b;
        a         = ref_regs[w[25:21]];
        b         = ref_regs[w[20:16]];
        r         = '0;
        r.next_pc = cur_pc + 32'd4;
        r.addr    = a + {{16{w[15]}}, w[15:0]};     // Base plus signed offset
        r.st_data = b;
        r.reg_wa  = w[20:16];
        case ({2'b00, w[31:26]})
            op_rtype: begin
                r.reg_we = 1'b1;
                r.reg_wa = w[15:11];
                case (w[5:0])
                    fn_add:  r.reg_wd = a + b;
                    fn_sub:  r.reg_wd = a - b;
                    fn_and:  r.reg_wd = a & b;
                    fn_or:   r.reg_wd = a | b;
                    fn_slt:  r.reg_wd = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: r.reg_we = 1'b0;
                endcase
            end
            op_addi: begin
                r.reg_we = 1'b1;
                r.reg_wd = r.addr;
            end
            op_lw: begin
                r.mem_access = 1'b1;
                r.reg_we     = 1'b1;
                r.reg_wd     = ref_mem[r.addr[7:2]];
            end
            op_sw: begin
                r.mem_access = 1'b1;
                r.mem_we     = 1'b1;
            end
            op_beq: begin
                if (a == b) begin
                    r.next_pc = cur_pc + 32'd4 + {{14{w[15]}}, w[15:0], 2'b00};
                end
            end
            op_j, op_jal: begin
                r.next_pc = {r.next_pc[31:28], w[25:0], 2'b00};
                r.reg_we  = (w[31:26] == op_jal[5:0]);
                r.reg_wa  = 5'd31;
                r.reg_wd  = cur_pc + 32'd4;     // Return address
            end
            default: ;
        endcase
        return r;
    endfunction

    task automatic check_word(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            errors++;
            $display("Fail at %0t: %s expected %h, actual %h", $time, name, expected, actual);
            $display("Checks failed");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            errors++;
            $display("Fail at %0t: %s expected %b, actual %b", $time, name, expected, actual);
            $display("Checks failed");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    initial begin
        clock    = 1'b0;
        rst_n    = 1'b0;
        instr    = '0;
        exp_pc   = reset_pc;
        fetch_on = 1'b0;
        errors   = 0;
        lfsr     = 32'h5a0e_03b8;
        for (int i = 0; i < 64; i++) begin
            dmem[i]    = (32'(i) * 32'h9e37_79b9) ^ 32'h5bd1_e995;
            ref_mem[i] = dmem[i];
        end
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = 32'd0;
        end
        build_program();
        // Core sees a store while reset is held
        repeat (reset_cycles - 1) begin
            @(negedge clock);
            check_word("pc", pc, reset_pc);
            check_bit("dmem_we", dmem_we, 1'b0);
        end
        fetch_on = 1'b1;                        // First program word on the release edge
        @(posedge clock);
        rst_n <= 1'b1;
    end

    // Compare mid-cycle, then advance the reference state
    initial begin : compare
        ref_result_t r;
        wait (rst_n === 1'b1);
        while (exp_pc < end_pc) begin
            @(negedge clock);
            r = exec_ref(exp_pc, imem[exp_pc[9:2]]);
            check_word("pc", pc, exp_pc);
            check_bit("dmem_we", dmem_we, r.mem_we);
            if (r.mem_access) begin
                check_word("dmem_addr", dmem_addr, r.addr);
            end
            if (r.mem_we) begin
                check_word("dmem_wd", dmem_wd, r.st_data);
                ref_mem[r.addr[7:2]] = r.st_data;
            end
            if (r.reg_we && (r.reg_wa != 5'd0)) begin
                ref_regs[r.reg_wa] = r.reg_wd;  // r0 stays zero
            end
            exp_pc = r.next_pc;
        end
        if (errors == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            $display("Checks failed");
            $fatal(1, "%0d mismatches", errors);
        end
    end

    // Watchdog
    initial begin
        #((prog_len + reset_cycles + margin) * clk_period);
        $display("Timeout: the core did not reach the end of the program in time");
        $display("Checks failed");
        $fatal(1, "Watchdog expired");
    end

endmodule

`default_nettype wire
